// File: hw/pipeCtrlPkg.sv
package pipeCtrlPkg;

  //////////////////////////////////////////////////
  // Register ids and opcodes
  //////////////////////////////////////////////////
  typedef logic [3:0] regIdT;  // Sixteen registers, r0 reads zero

  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,
    OP_SUB    = 4'h1,
    OP_XOR    = 4'h2,
    OP_RED    = 4'h3,
    OP_SLL    = 4'h4,
    OP_SRA    = 4'h5,
    OP_ROR    = 4'h6,
    OP_PADDSB = 4'h7,
    OP_LW     = 4'h8,
    OP_SW     = 4'h9,
    OP_LLB    = 4'hA,
    OP_LHB    = 4'hB,
    OP_B      = 4'hC,
    OP_BR     = 4'hD,
    OP_PCS    = 4'hE,
    OP_HLT    = 4'hF
  } opcodeT;

  //////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////
  typedef struct packed {
    opcodeT opcode;
    regIdT  rd;  // Destination
    regIdT  rs;
    regIdT  rt;
  } rFormT;

  typedef struct packed {
    opcodeT     opcode;
    regIdT      rt;      // LW dest, SW data, LLB/LHB src and dest
    regIdT      rs;      // Base address register
    logic [3:0] offset;
  } memFormT;

  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] cond;   // Flag condition code
    logic [8:0] label;  // BR keeps its target register in bits 7:4
  } brFormT;

  // One fetched word seen through each format
  typedef union packed {
    rFormT   rForm;
    memFormT memForm;
    brFormT  brForm;
  } instrT;

  localparam logic [15:0] NOP_INSTR = 16'h0000;  // ADD r0, r0, r0

endpackage

// File: hw/decodeIf.sv
`timescale 1ns/1ns
`default_nettype none

// Decoded control of the instruction sitting in ID
interface decodeIf;
  import pipeCtrlPkg::*;

  regIdT srcReg1;   // Rs, or rt for LLB/LHB
  regIdT srcReg2;   // Rt, or SW data register
  regIdT destReg;
  logic  regWrite;
  logic  memEnable;
  logic  memWrite;
  logic  zEn;       // Sets the zero flag
  logic  nvEn;      // Sets negative and overflow flags
  logic  branch;    // B or BR
  logic  br;        // BR only
  logic  hlt;

  modport producer (
    output srcReg1, srcReg2, destReg, regWrite, memEnable, memWrite,
    output zEn, nvEn, branch, br, hlt
  );

  modport consumer (
    input srcReg1, srcReg2, destReg, regWrite, memEnable, memWrite,
    input zEn, nvEn, branch, br, hlt
  );

endinterface

`default_nettype wire

// File: hw/stageIf.sv
`timescale 1ns/1ns
`default_nettype none

// Control shadow of ID/EX and EX/MEM fed back to the hazard logic
interface stageIf;
  import pipeCtrlPkg::*;

  regIdT idExRd;
  logic  idExRegWrite;
  logic  idExMemEnable;
  logic  idExMemWrite;
  logic  idExZEn;
  logic  idExNvEn;
  regIdT exMemRd;
  logic  exMemRegWrite;

  modport producer (
    output idExRd, idExRegWrite, idExMemEnable, idExMemWrite, idExZEn, idExNvEn,
    output exMemRd, exMemRegWrite
  );

  modport consumer (
    input idExRd, idExRegWrite, idExMemEnable, idExMemWrite, idExZEn, idExNvEn,
    input exMemRd, exMemRegWrite
  );

endinterface

`default_nettype wire

// File: hw/ifIdReg.sv
`timescale 1ns/1ns
`default_nettype none

// IF/ID instruction register
module ifIdReg (
  input  logic              clk,
  input  logic              rst,
  input  pipeCtrlPkg::instrT instr,      // Word from fetch
  input  logic              ifIdStall,  // Hold current word
  input  logic              ifFlush,    // Discard fetched word
  output pipeCtrlPkg::instrT idInstr     // Word in ID
);
  import pipeCtrlPkg::*;

  //////////////////////////////////////////////////
  // Instruction register
  //////////////////////////////////////////////////
  // Flush wins over stall so a redirect always kills the word
  always_ff @(posedge clk) begin
    if (rst || ifFlush) begin
      idInstr <= NOP_INSTR;  // Bubble into ID
    end else if (!ifIdStall) begin
      idInstr <= instr;
    end
    // Stalled word stays put until the hazard clears
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // A stalled word must still be in ID one cycle later
  property holdOnStall;
    @(posedge clk) disable iff (rst)
      (ifIdStall && !ifFlush) |=> $stable(idInstr);
  endproperty

  holdOnStallA: assert property (holdOnStall)
    else $error("IF/ID word changed during a stall");

endmodule

`default_nettype wire

// File: hw/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

// Extracts register ids and control bits from the word in ID
module instrDecoder (
  input pipeCtrlPkg::instrT idInstr,
  decodeIf.producer         dec
);
  import pipeCtrlPkg::*;

  opcodeT opcode;  // Same field in every format

  assign opcode = idInstr.rForm.opcode;

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  always_comb begin
    // Unused sources read r0, which never matches a hazard
    dec.srcReg1   = '0;
    dec.srcReg2   = '0;
    dec.destReg   = '0;
    dec.regWrite  = 1'b0;
    dec.memEnable = 1'b0;
    dec.memWrite  = 1'b0;
    dec.zEn       = 1'b0;
    dec.nvEn      = 1'b0;
    dec.branch    = 1'b0;
    dec.br        = 1'b0;
    dec.hlt       = 1'b0;

    // The filler word is a bubble and carries no control
    if (idInstr != NOP_INSTR) begin
      unique case (opcode)
        OP_ADD, OP_SUB, OP_XOR, OP_RED, OP_SLL, OP_SRA, OP_ROR, OP_PADDSB: begin
          dec.srcReg1  = idInstr.rForm.rs;
          dec.srcReg2  = idInstr.rForm.rt;
          dec.destReg  = idInstr.rForm.rd;
          dec.regWrite = 1'b1;
          // RED and PADDSB leave the flags alone
          dec.zEn      = (opcode != OP_RED) && (opcode != OP_PADDSB);
          dec.nvEn     = (opcode == OP_ADD) || (opcode == OP_SUB);
        end
        OP_LW: begin
          dec.srcReg1   = idInstr.memForm.rs;  // Base
          dec.destReg   = idInstr.memForm.rt;
          dec.regWrite  = 1'b1;
          dec.memEnable = 1'b1;
        end
        OP_SW: begin
          dec.srcReg1   = idInstr.memForm.rs;  // Base
          dec.srcReg2   = idInstr.memForm.rt;  // Store data
          dec.memEnable = 1'b1;
          dec.memWrite  = 1'b1;
        end
        OP_LLB, OP_LHB: begin
          // Half of rt is kept so it is read as well as written
          dec.srcReg1  = idInstr.memForm.rt;
          dec.destReg  = idInstr.memForm.rt;
          dec.regWrite = 1'b1;
        end
        OP_B: begin
          dec.branch = 1'b1;  // Condition only, no register read
        end
        OP_BR: begin
          dec.srcReg1 = idInstr.brForm.label[7:4];  // Target register
          dec.branch  = 1'b1;
          dec.br      = 1'b1;
        end
        OP_PCS: begin
          dec.destReg  = idInstr.rForm.rd;  // Gets PC+2
          dec.regWrite = 1'b1;
        end
        OP_HLT: begin
          dec.hlt = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/hazardDetectionUnit.sv
`timescale 1ns/1ns
`default_nettype none

// Load-to-use and branch hazard detection for the ID stage
module hazardDetectionUnit (
  decodeIf.consumer dec,        // Instruction in ID
  stageIf.consumer  stg,        // ID/EX and EX/MEM control
  input  logic      updatePc,   // Branch resolved taken
  output logic      pcStall,
  output logic      ifIdStall,
  output logic      idFlush,    // Bubble into ID/EX
  output logic      ifFlush     // Kill word in IF/ID
);

  logic idExMemRead;    // LW in EX
  logic idExSetsFlags;  // Flags not yet written back for the branch
  logic loadUseHazard;
  logic bHazard;
  logic brInst;
  logic exToIdHazBr;    // EX producer of the BR target
  logic memToIdHazBr;   // MEM producer of the BR target
  logic brHazard;

  //////////////////////////////////////////////////
  // Stall and flush levels
  //////////////////////////////////////////////////
  assign pcStall   = dec.hlt | loadUseHazard | bHazard | brHazard;  // Halt freezes fetch too
  assign ifIdStall = pcStall;
  assign idFlush   = loadUseHazard | bHazard | brHazard;  // Not for halt
  assign ifFlush   = updatePc;  // Wrong-path word in IF/ID

  //////////////////////////////////////////////////
  // Load-to-use
  //////////////////////////////////////////////////
  assign idExMemRead = stg.idExMemEnable & ~stg.idExMemWrite;

  // SW data gets MEM-MEM forwarding, so only its base counts
  assign loadUseHazard = idExMemRead & (stg.idExRd != 4'h0) &
                         ((stg.idExRd == dec.srcReg1) |
                          ((stg.idExRd == dec.srcReg2) & ~dec.memWrite));

  //////////////////////////////////////////////////
  // Branches
  //////////////////////////////////////////////////
  assign idExSetsFlags = stg.idExZEn | stg.idExNvEn;

  // B and BR both wait on flags from EX
  assign bHazard = dec.branch & idExSetsFlags;

  assign brInst = dec.branch & dec.br;

  // Target register still being produced
  assign exToIdHazBr  = stg.idExRegWrite & (stg.idExRd != 4'h0) &
                        (stg.idExRd == dec.srcReg1);
  assign memToIdHazBr = stg.exMemRegWrite & (stg.exMemRd != 4'h0) &
                        (stg.exMemRd == dec.srcReg1);

  assign brHazard = brInst & (idExSetsFlags | exToIdHazBr | memToIdHazBr);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // A bubble is only safe if the held word is replayed from IF/ID
  always_comb begin
    assert final (!idFlush || (pcStall && ifIdStall))
      else $error("ID/EX flushed while IF/ID was not held");
  end

endmodule

`default_nettype wire

// File: hw/stageTracker.sv
`timescale 1ns/1ns
`default_nettype none

// Control shadow of ID/EX and EX/MEM with issue report
module stageTracker (
  input  logic               clk,
  input  logic               rst,
  decodeIf.consumer          dec,
  input  logic               idFlush,
  input  pipeCtrlPkg::instrT idInstr,
  stageIf.producer           stg,
  output logic               issueValid,  // A real instruction entered ID/EX
  output pipeCtrlPkg::instrT issueInstr
);
  import pipeCtrlPkg::*;

  logic bubble;  // Nothing real moves into ID/EX

  // Hazard bubble, halt held in ID or filler word
  assign bubble = idFlush | dec.hlt | (idInstr == NOP_INSTR);

  //////////////////////////////////////////////////
  // ID/EX and EX/MEM shadow
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      stg.idExRd        <= '0;
      stg.idExRegWrite  <= 1'b0;
      stg.idExMemEnable <= 1'b0;
      stg.idExMemWrite  <= 1'b0;
      stg.idExZEn       <= 1'b0;
      stg.idExNvEn      <= 1'b0;
      stg.exMemRd       <= '0;
      stg.exMemRegWrite <= 1'b0;
      issueValid        <= 1'b0;
    end else begin
      stg.idExRd        <= bubble ? '0   : dec.destReg;
      stg.idExRegWrite  <= bubble ? 1'b0 : dec.regWrite;
      stg.idExMemEnable <= bubble ? 1'b0 : dec.memEnable;
      stg.idExMemWrite  <= bubble ? 1'b0 : dec.memWrite;
      stg.idExZEn       <= bubble ? 1'b0 : dec.zEn;
      stg.idExNvEn      <= bubble ? 1'b0 : dec.nvEn;
      stg.exMemRd       <= stg.idExRd;        // Flags and memory are done by MEM
      stg.exMemRegWrite <= stg.idExRegWrite;
      issueValid        <= ~bubble;
    end
  end

  // Word moving from ID into ID/EX on this edge
  always_ff @(posedge clk) begin
    issueInstr <= idInstr;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  property bubbleIsInert;
    @(posedge clk) disable iff (rst)
      bubble |=> (!stg.idExRegWrite && !stg.idExMemEnable && !issueValid);
  endproperty

  bubbleIsInertA: assert property (bubbleIsInert)
    else $error("Bubble in ID/EX carries write or memory control");

endmodule

`default_nettype wire

// File: hw/pipeCtrlTop.sv
`timescale 1ns/1ns
`default_nettype none

// Hazard control slice of the five-stage pipeline
module pipeCtrlTop (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] instr,       // Fetched word
  input  logic        updatePc,    // Taken branch redirect
  output logic        pcStall,
  output logic        ifIdStall,
  output logic        idFlush,
  output logic        ifFlush,
  output logic        issueValid,
  output logic [15:0] issueInstr   // Word entering ID/EX
);
  import pipeCtrlPkg::*;

  instrT idInstr;  // Word held in IF/ID

  decodeIf decBus ();
  stageIf  stgBus ();

  //////////////////////////////////////////////////
  // IF/ID and decode
  //////////////////////////////////////////////////
  ifIdReg i_ifIdReg (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .ifIdStall (ifIdStall),
    .ifFlush   (ifFlush),
    .idInstr   (idInstr)
  );

  instrDecoder i_instrDecoder (
    .idInstr (idInstr),
    .dec     (decBus)
  );

  //////////////////////////////////////////////////
  // Hazards and stage shadow
  //////////////////////////////////////////////////
  hazardDetectionUnit i_hazardDetectionUnit (
    .dec       (decBus),
    .stg       (stgBus),
    .updatePc  (updatePc),
    .pcStall   (pcStall),
    .ifIdStall (ifIdStall),
    .idFlush   (idFlush),
    .ifFlush   (ifFlush)
  );

  stageTracker i_stageTracker (
    .clk        (clk),
    .rst        (rst),
    .dec        (decBus),
    .idFlush    (idFlush),
    .idInstr    (idInstr),
    .stg        (stgBus),
    .issueValid (issueValid),
    .issueInstr (issueInstr)
  );

endmodule

`default_nettype wire

// File: sim/hazardTable.svh
  // One fetched word per row, offered in order by the fetch model
  // Columns: word, redirect with updatePc, stall cycles while in ID, issues to ID/EX
  task automatic loadTable();
    // Load-to-use
    addRow(16'h0000, 1'b0, 0, 1'b0);  // NOP
    addRow(16'h8310, 1'b0, 0, 1'b1);  // LW r3, 0(r1)
    addRow(16'h0432, 1'b0, 1, 1'b1);  // ADD r4, r3, r2 waits for the load
    addRow(16'h0000, 1'b0, 0, 1'b0);
    addRow(16'h8010, 1'b0, 0, 1'b1);  // LW r0 never blocks
    addRow(16'h0502, 1'b0, 0, 1'b1);  // ADD r5, r0, r2
    addRow(16'h0000, 1'b0, 0, 1'b0);
    addRow(16'h8310, 1'b0, 0, 1'b1);  // LW r3
    addRow(16'h9320, 1'b0, 0, 1'b1);  // SW r3, 0(r2), data is forwarded
    addRow(16'h0000, 1'b0, 0, 1'b0);

    // B waits on flags from EX
    addRow(16'h1612, 1'b0, 0, 1'b1);  // SUB r6, r1, r2
    addRow(16'hC004, 1'b0, 1, 1'b1);  // B
    addRow(16'h0000, 1'b0, 0, 1'b0);
    addRow(16'h8710, 1'b0, 0, 1'b1);  // LW r7 sets no flags
    addRow(16'hC004, 1'b0, 0, 1'b1);
    addRow(16'h0000, 1'b0, 0, 1'b0);

    // BR target register and flags
    addRow(16'h0512, 1'b0, 0, 1'b1);  // ADD r5, r1, r2
    addRow(16'hD050, 1'b0, 2, 1'b1);  // BR r5 right behind the producer
    addRow(16'h0000, 1'b0, 0, 1'b0);
    addRow(16'h0512, 1'b0, 0, 1'b1);  // ADD r5
    addRow(16'h7912, 1'b0, 0, 1'b1);  // PADDSB r9, no flags
    addRow(16'hD050, 1'b0, 1, 1'b1);  // Producer now in MEM
    addRow(16'h0000, 1'b0, 0, 1'b0);
    addRow(16'h2A12, 1'b0, 0, 1'b1);  // XOR r10 sets Z
    addRow(16'hD050, 1'b0, 1, 1'b1);  // Flag wait only
    addRow(16'h0000, 1'b0, 0, 1'b0);

    // Taken branch kills the wrong-path fetch
    addRow(16'hC004, 1'b0, 0, 1'b1);
    addRow(16'h1B12, 1'b1, 0, 1'b0);  // SUB r11 flushed
    addRow(16'h0C12, 1'b0, 0, 1'b1);  // ADD r12 at the target
    addRow(16'h0000, 1'b0, 0, 1'b0);

    // Load-to-use through the second source
    addRow(16'h8310, 1'b0, 0, 1'b1);
    addRow(16'h1D13, 1'b0, 1, 1'b1);  // SUB r13, r1, r3
    addRow(16'h0000, 1'b0, 0, 1'b0);
  endtask

// File: sim/pipeCtrlTb.sv
`timescale 1ns/1ns

module pipeCtrlTb;
  import pipeCtrlPkg::*;

  localparam int settleNs   = 10;  // Sample point after the falling edge
  localparam int stallLimit = 8;

  typedef struct packed {
    logic [15:0] word;
    logic        redirect;  // Pulse updatePc with this word
    logic [3:0]  stalls;    // Stall cycles while the word sits in ID
    logic        issues;
  } rowT;

  logic        clk;
  logic        rst;
  logic [15:0] instr;
  logic        updatePc;
  logic        pcStall;
  logic        ifIdStall;
  logic        idFlush;
  logic        ifFlush;
  logic        issueValid;
  logic [15:0] issueInstr;
  rowT         rows[$];
  logic [15:0] expectIssue[$];  // Words still owed to ID/EX, in order
  logic        watchIssue;
  int          stallCount;

  pipeCtrlTop i_pipeCtrlTop (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .updatePc   (updatePc),
    .pcStall    (pcStall),
    .ifIdStall  (ifIdStall),
    .idFlush    (idFlush),
    .ifFlush    (ifFlush),
    .issueValid (issueValid),
    .issueInstr (issueInstr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////
  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic expectValue(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
      else stopRun($sformatf("FAILED %s: got 0x%04h, expected 0x%04h", name, got, exp));
  endtask

  task automatic expectBit(input string name, input logic got, input logic exp);
    assert (got === exp)
      else stopRun($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic checkIdle();
    expectBit("pcStall", pcStall, 1'b0);
    expectBit("ifIdStall", ifIdStall, 1'b0);
    expectBit("idFlush", idFlush, 1'b0);
    expectBit("ifFlush", ifFlush, 1'b0);
    expectBit("issueValid", issueValid, 1'b0);
  endtask

  task automatic addRow(input logic [15:0] word, input logic redirect, input int stalls,
                        input logic issues);
    rows.push_back(rowT'{word, redirect, stalls[3:0], issues});
  endtask

  `include "hazardTable.svh"

  //////////////////////////////////////////////////
  // Fetch model
  //////////////////////////////////////////////////
  // Offers a word and holds it while ID stalls; returns the stalls of the word in ID
  task automatic presentWord(input logic [15:0] word, input logic redirect, output int stalls);
    stalls = 0;
    @(negedge clk);
    instr    = word;
    updatePc = redirect;
    #settleNs;
    expectBit("ifFlush", ifFlush, redirect);  // Same-cycle redirect
    while (pcStall) begin
      expectBit("idFlush", idFlush, 1'b1);    // Every table stall is a hazard
      expectBit("ifIdStall", ifIdStall, 1'b1);
      assert (stalls < stallLimit) else stopRun("Stall in ID did not clear in time");
      stalls++;
      @(negedge clk);
      #settleNs;
    end
    expectBit("idFlush", idFlush, 1'b0);
    expectBit("ifIdStall", ifIdStall, 1'b0);
  endtask

  // Each issue must be the next word owed by the table
  always @(negedge clk) begin
    if (watchIssue && issueValid) begin
      assert (expectIssue.size() > 0) else stopRun("A word issued that was not expected");
      expectValue("issueInstr", issueInstr, expectIssue.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    rst        = 1'b1;
    instr      = NOP_INSTR;
    updatePc   = 1'b0;
    watchIssue = 1'b0;
    loadTable();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    #settleNs;
    checkIdle();
    watchIssue = 1'b1;

    foreach (rows[i]) begin
      if (rows[i].issues) begin
        expectIssue.push_back(rows[i].word);  // Owed once it leaves ID
      end
      presentWord(rows[i].word, rows[i].redirect, stallCount);
      if (i > 0) begin
        expectValue($sformatf("stalls of row %0d", i - 1), 16'(stallCount),
                    16'(rows[i - 1].stalls));
      end
    end
    presentWord(NOP_INSTR, 1'b0, stallCount);  // Flushes out the last row
    expectValue("stalls of last row", 16'(stallCount), 16'(rows[rows.size() - 1].stalls));

    for (int n = 0; expectIssue.size() > 0; n++) begin
      assert (n < stallLimit) else stopRun("Table words never reached ID/EX");
      @(negedge clk);
      #settleNs;
    end

    // HLT freezes fetch until reset
    presentWord(16'hF000, 1'b0, stallCount);
    @(negedge clk);
    instr = NOP_INSTR;
    repeat (20) begin
      #settleNs;
      expectBit("pcStall", pcStall, 1'b1);
      expectBit("ifIdStall", ifIdStall, 1'b1);
      expectBit("idFlush", idFlush, 1'b0);  // Halt is not a hazard
      @(negedge clk);
    end
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    #settleNs;
    checkIdle();

    $display("Test OK");
    $finish;
  end

endmodule

// File: project.f
+incdir+sim
hw/pipeCtrlPkg.sv
hw/decodeIf.sv
hw/stageIf.sv
hw/ifIdReg.sv
hw/instrDecoder.sv
hw/hazardDetectionUnit.sv
hw/stageTracker.sv
hw/pipeCtrlTop.sv
sim/pipeCtrlTb.sv

// File: Makefile
TOP := pipeCtrlTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f hw/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
